// File: design/cpuPkg.sv
`default_nettype none

package cpuPkg;

   // Number of architectural registers with X31 as the zero register
   localparam int REG_COUNT = 32;

   // Register-register format
   typedef struct packed {
      logic [10:0] opcode;
      logic [4:0]  rm;
      logic [5:0]  shamt;
      logic [4:0]  rn;
      logic [4:0]  rd;
   } rFmtT;

   // Immediate format used by ADDI and SUBI
   typedef struct packed {
      logic [9:0]  opcode;
      logic [11:0] imm12;
      logic [4:0]  rn;
      logic [4:0]  rd;
   } iFmtT;

   // Data transfer format
   // rt is the load target or store source
   typedef struct packed {
      logic [10:0] opcode;
      logic [8:0]  daddr9;
      logic [1:0]  op2;
      logic [4:0]  rn;
      logic [4:0]  rt;
   } dFmtT;

   // Wide immediate format for MOVZ and MOVK
   typedef struct packed {
      logic [8:0]  opcode;
      logic [1:0]  hw;
      logic [15:0] imm16;
      logic [4:0]  rd;
   } iwFmtT;

   // One instruction word read through whichever format applies
   typedef union packed {
      rFmtT  r;
      iFmtT  i;
      dFmtT  d;
      iwFmtT iw;
   } instWordT;

   // ALU operation codes
   typedef enum logic [2:0] {
      ALU_PASSB = 3'b000,
      ALU_ADD   = 3'b010,
      ALU_SUB   = 3'b011,
      ALU_AND   = 3'b100,
      ALU_ORR   = 3'b101,
      ALU_EOR   = 3'b110
   } aluOpT;

   typedef struct packed {
      logic  regWrite;
      logic  memWrite;
      logic  memRead;
      logic  memToReg;
      logic  xferByte;
      logic  setFlags;
      logic  useImm12;
      logic  useDaddr9;
      logic  chooseMovk;
      logic  chooseMovz;
      aluOpT aluOp;
   } ctrlT;

   typedef struct packed {
      logic negative;
      logic zero;
      logic overflow;
      logic carry;
   } flagsT;

   // Decode to execute pipeline record
   typedef struct packed {
      ctrlT        ctrl;
      logic [4:0]  rd;
      logic [4:0]  rn;
      // Second read address is rd for stores and MOVK
      logic [4:0]  rm;
      logic [63:0] opA;
      logic [63:0] opB;
      logic [11:0] imm12;
      logic [8:0]  daddr9;
      logic [15:0] imm16;
      logic [1:0]  hw;
      logic        valid;
   } decExT;

   // Execute to result pipeline record
   typedef struct packed {
      logic        valid;
      ctrlT        ctrl;
      logic [4:0]  rd;
      logic [63:0] aluOut;
      logic [63:0] storeData;
      flagsT       aluFlags;
   } exResT;

   // Register write record that also serves as the forwarding path
   typedef struct packed {
      logic        valid;
      logic [4:0]  rd;
      logic [63:0] data;
   } fwdT;

   typedef struct packed {
      logic        valid;
      logic        writes;
      logic [4:0]  rd;
      logic [63:0] data;
      flagsT       flags;
   } retireT;

endpackage

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic              clk,
   input  logic              arstN,
   input  logic [4:0]        rdAddrA,
   input  logic [4:0]        rdAddrB,
   output logic [63:0]       rdDataA,
   output logic [63:0]       rdDataB,
   input  cpuPkg::fwdT       wr
   );

   logic [63:0] regs [0:cpuPkg::REG_COUNT-1];

   // Write on the rising edge, X31 is never stored
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < cpuPkg::REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.valid && wr.rd != 5'd31) begin
         regs[wr.rd] <= wr.data;
      end
   end

   // Read ports
   // X31 forced to zero, a same-cycle write goes straight through
   always_comb begin
      if (rdAddrA == 5'd31) rdDataA = '0;
      else if (wr.valid && wr.rd == rdAddrA) rdDataA = wr.data;
      else rdDataA = regs[rdAddrA];
   end

   always_comb begin
      if (rdAddrB == 5'd31) rdDataB = '0;
      else if (wr.valid && wr.rd == rdAddrB) rdDataB = wr.data;
      else rdDataB = regs[rdAddrB];
   end

endmodule

`default_nettype wire

// File: design/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
   input  logic             clk,
   input  logic             arstN,
   input  logic             instValid,
   input  cpuPkg::instWordT instWord,
   input  cpuPkg::fwdT      regWr,
   output cpuPkg::decExT    decOut
   );

   // LEGv8 opcodes
   localparam logic [10:0] OP_ADD   = 11'h458;
   localparam logic [10:0] OP_ADDS  = 11'h558;
   localparam logic [10:0] OP_SUB   = 11'h658;
   localparam logic [10:0] OP_SUBS  = 11'h758;
   localparam logic [10:0] OP_AND   = 11'h450;
   localparam logic [10:0] OP_ORR   = 11'h550;
   localparam logic [10:0] OP_EOR   = 11'h650;
   localparam logic [10:0] OP_LDUR  = 11'h7C2;
   localparam logic [10:0] OP_STUR  = 11'h7C0;
   localparam logic [10:0] OP_LDURB = 11'h1C2;
   localparam logic [10:0] OP_STURB = 11'h1C0;
   localparam logic [9:0]  OP_ADDI  = 10'h244;
   localparam logic [9:0]  OP_SUBI  = 10'h344;
   localparam logic [8:0]  OP_MOVZ  = 9'h1A5;
   localparam logic [8:0]  OP_MOVK  = 9'h1E5;

   cpuPkg::ctrlT  ctrl;
   cpuPkg::decExT decNext;
   logic          readRd;
   logic [4:0]    rdAddrB;
   logic [63:0]   rdDataA;
   logic [63:0]   rdDataB;

   // Control decode
   // Unmatched opcodes keep the all-zero control word and retire as no-ops
   always_comb begin
      ctrl = '0;
      ctrl.aluOp = cpuPkg::ALU_PASSB;
      readRd = 1'b0;
      if (instWord.iw.opcode == OP_MOVZ) begin
         ctrl.regWrite = 1'b1;
         ctrl.chooseMovz = 1'b1;
      end else if (instWord.iw.opcode == OP_MOVK) begin
         // Old rd value is needed for the field merge
         ctrl.regWrite = 1'b1;
         ctrl.chooseMovk = 1'b1;
         readRd = 1'b1;
      end else if (instWord.i.opcode == OP_ADDI || instWord.i.opcode == OP_SUBI) begin
         ctrl.regWrite = 1'b1;
         ctrl.useImm12 = 1'b1;
         ctrl.aluOp = (instWord.i.opcode == OP_SUBI) ? cpuPkg::ALU_SUB : cpuPkg::ALU_ADD;
      end else begin
         // Register-register group
         case (instWord.r.opcode)
            OP_ADD, OP_ADDS: ctrl.aluOp = cpuPkg::ALU_ADD;
            OP_SUB, OP_SUBS: ctrl.aluOp = cpuPkg::ALU_SUB;
            OP_AND:          ctrl.aluOp = cpuPkg::ALU_AND;
            OP_ORR:          ctrl.aluOp = cpuPkg::ALU_ORR;
            OP_EOR:          ctrl.aluOp = cpuPkg::ALU_EOR;
            default:         ctrl.aluOp = cpuPkg::ALU_PASSB;
         endcase
         if (ctrl.aluOp != cpuPkg::ALU_PASSB) ctrl.regWrite = 1'b1;
         if (instWord.r.opcode == OP_ADDS || instWord.r.opcode == OP_SUBS) begin
            ctrl.setFlags = 1'b1;
         end
         // Data transfer group, address is rn plus daddr9
         case (instWord.d.opcode)
            OP_LDUR, OP_LDURB: begin
               ctrl.regWrite = 1'b1;
               ctrl.memRead = 1'b1;
               ctrl.memToReg = 1'b1;
               ctrl.useDaddr9 = 1'b1;
               ctrl.aluOp = cpuPkg::ALU_ADD;
               ctrl.xferByte = (instWord.d.opcode == OP_LDURB);
            end
            OP_STUR, OP_STURB: begin
               ctrl.memWrite = 1'b1;
               ctrl.useDaddr9 = 1'b1;
               ctrl.aluOp = cpuPkg::ALU_ADD;
               ctrl.xferByte = (instWord.d.opcode == OP_STURB);
               readRd = 1'b1;
            end
            default: ;
         endcase
      end
      // X31 is the zero register
      if (instWord.r.rd == 5'd31) ctrl.regWrite = 1'b0;
      // Bubble carries no side effects
      if (!instValid) ctrl = '0;
   end

   // Stores and MOVK read rd on the second port
   assign rdAddrB = readRd ? instWord.r.rd : instWord.r.rm;

   regFile u_regFile (
      .clk     (clk),
      .arstN   (arstN),
      .rdAddrA (instWord.r.rn),
      .rdAddrB (rdAddrB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wr      (regWr)
   );

   always_comb begin
      decNext.ctrl = ctrl;
      decNext.rd = instWord.r.rd;
      decNext.rn = instWord.r.rn;
      decNext.rm = rdAddrB;
      decNext.opA = rdDataA;
      decNext.opB = rdDataB;
      decNext.imm12 = instWord.i.imm12;
      decNext.daddr9 = instWord.d.daddr9;
      decNext.imm16 = instWord.iw.imm16;
      decNext.hw = instWord.iw.hw;
      decNext.valid = instValid;
   end

   // Decode to execute register
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) decOut <= '0;
      else decOut <= decNext;
   end

endmodule

`default_nettype wire

// File: design/execStage.sv
`timescale 1ns/1ps
`default_nettype none

module execStage (
   input  logic          clk,
   input  logic          arstN,
   input  cpuPkg::decExT decOut,
   input  cpuPkg::fwdT   fwd,
   output cpuPkg::exResT exOut
   );

   logic [63:0]   regA;
   logic [63:0]   regB;
   logic [5:0]    fieldShift;
   logic [63:0]   fieldMask;
   logic [63:0]   movzVal;
   logic [63:0]   movkVal;
   logic [63:0]   aluA;
   logic [63:0]   aluB;
   logic [64:0]   addFull;
   logic [64:0]   subFull;
   logic [63:0]   aluRes;
   cpuPkg::flagsT aluFlags;
   cpuPkg::exResT exNext;

   // Forwarding from the result stage, X31 never forwarded
   assign regA = (fwd.valid && fwd.rd == decOut.rn && decOut.rn != 5'd31)
                 ? fwd.data : decOut.opA;
   assign regB = (fwd.valid && fwd.rd == decOut.rm && decOut.rm != 5'd31)
                 ? fwd.data : decOut.opB;

   // MOVZ and MOVK
   // hw picks one of four 16-bit fields
   assign fieldShift = {decOut.hw, 4'b0000};
   assign movzVal = {48'b0, decOut.imm16} << fieldShift;
   assign fieldMask = 64'hFFFF << fieldShift;
   // Clear the target field of the old value, then drop imm16 in
   assign movkVal = (regB & ~fieldMask) | movzVal;

   // Operand B priority
   always_comb begin
      if (decOut.ctrl.useImm12) aluB = {52'b0, decOut.imm12};
      else if (decOut.ctrl.useDaddr9) aluB = {{55{decOut.daddr9[8]}}, decOut.daddr9};
      else if (decOut.ctrl.chooseMovk) aluB = movkVal;
      else if (decOut.ctrl.chooseMovz) aluB = movzVal;
      else aluB = regB;
   end

   assign aluA = regA;

   // Extra top bit of the sums is the carry
   // Subtract as A plus not B plus one, so carry set means no borrow
   assign addFull = {1'b0, aluA} + {1'b0, aluB};
   assign subFull = {1'b0, aluA} + {1'b0, ~aluB} + 65'd1;

   always_comb begin
      aluFlags.carry = 1'b0;
      aluFlags.overflow = 1'b0;
      case (decOut.ctrl.aluOp)
         cpuPkg::ALU_ADD: begin
            aluRes = addFull[63:0];
            aluFlags.carry = addFull[64];
            // Same-sign inputs giving a different-sign sum
            aluFlags.overflow = (aluA[63] == aluB[63]) && (aluRes[63] != aluA[63]);
         end
         cpuPkg::ALU_SUB: begin
            aluRes = subFull[63:0];
            aluFlags.carry = subFull[64];
            aluFlags.overflow = (aluA[63] != aluB[63]) && (aluRes[63] != aluA[63]);
         end
         cpuPkg::ALU_AND: aluRes = aluA & aluB;
         cpuPkg::ALU_ORR: aluRes = aluA | aluB;
         cpuPkg::ALU_EOR: aluRes = aluA ^ aluB;
         default:         aluRes = aluB;
      endcase
      aluFlags.negative = aluRes[63];
      aluFlags.zero = (aluRes == 64'd0);
   end

   always_comb begin
      exNext.valid = decOut.valid;
      exNext.ctrl = decOut.ctrl;
      exNext.rd = decOut.rd;
      exNext.aluOut = aluRes;
      // Store data is the forwarded rt value
      exNext.storeData = regB;
      exNext.aluFlags = aluFlags;
   end

   // Execute to result register
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) exOut <= '0;
      else exOut <= exNext;
   end

endmodule

`default_nettype wire

// File: design/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

module resultStage #(
   parameter int MEM_BYTES = 256
   ) (
   input  logic           clk,
   input  logic           arstN,
   input  cpuPkg::exResT  exOut,
   output cpuPkg::fwdT    fwd,
   output cpuPkg::fwdT    regWr,
   output cpuPkg::retireT retire
   );

   localparam int ADDR_W = (MEM_BYTES > 1) ? $clog2(MEM_BYTES) : 1;

   logic [7:0]        mem [0:MEM_BYTES-1];
   logic [ADDR_W-1:0] byteAddr [0:7];
   logic [63:0]       rawLoad;
   logic [63:0]       loadData;
   logic [63:0]       wbData;
   cpuPkg::flagsT     flagsQ;
   cpuPkg::flagsT     flagsNext;
   cpuPkg::fwdT       wb;

   // Little-endian byte lanes, addresses wrap at MEM_BYTES
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         byteAddr[i] = ADDR_W'((exOut.aluOut + 64'(i)) % 64'(MEM_BYTES));
         rawLoad[i*8 +: 8] = mem[byteAddr[i]];
      end
   end

   // Byte stores touch lane 0 only
   always_ff @(posedge clk) begin
      if (exOut.valid && exOut.ctrl.memWrite) begin
         for (int i = 0; i < 8; i++) begin
            if (i == 0 || !exOut.ctrl.xferByte) begin
               mem[byteAddr[i]] <= exOut.storeData[i*8 +: 8];
            end
         end
      end
   end

   // LDURB zero-extends the low byte
   always_comb begin
      if (!exOut.ctrl.memRead) loadData = '0;
      else if (exOut.ctrl.xferByte) loadData = {56'b0, rawLoad[7:0]};
      else loadData = rawLoad;
   end

   assign wbData = exOut.ctrl.memToReg ? loadData : exOut.aluOut;

   // One writeback record feeds both the bypass and the register file
   assign wb.valid = exOut.valid && exOut.ctrl.regWrite;
   assign wb.rd = exOut.rd;
   assign wb.data = wbData;
   assign fwd = wb;
   assign regWr = wb;

   // Flags only move on ADDS and SUBS
   assign flagsNext = (exOut.valid && exOut.ctrl.setFlags) ? exOut.aluFlags : flagsQ;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) flagsQ <= '0;
      else flagsQ <= flagsNext;
   end

   // Retire record already shows this instruction's flags
   assign retire.valid = exOut.valid;
   assign retire.writes = wb.valid;
   assign retire.rd = exOut.rd;
   assign retire.data = wbData;
   assign retire.flags = flagsNext;

endmodule

`default_nettype wire

// File: design/cpuDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath #(
   parameter int MEM_BYTES = 256
   ) (
   input  logic             clk,
   input  logic             arstN,
   input  logic             instValid,
   input  cpuPkg::instWordT instWord,
   output cpuPkg::retireT   retire
   );

   // Pipeline records between stages
   cpuPkg::decExT decOut;
   cpuPkg::exResT exOut;
   // Paths back from the result stage
   cpuPkg::fwdT   fwd;
   cpuPkg::fwdT   regWr;

   // Decode with register read
   instDecoder u_instDecoder (
      .clk       (clk),
      .arstN     (arstN),
      .instValid (instValid),
      .instWord  (instWord),
      .regWr     (regWr),
      .decOut    (decOut)
   );

   // Operand select, MOVZ/MOVK merge and ALU
   execStage u_execStage (
      .clk    (clk),
      .arstN  (arstN),
      .decOut (decOut),
      .fwd    (fwd),
      .exOut  (exOut)
   );

   // Data memory, writeback and flags
   resultStage #(
      .MEM_BYTES (MEM_BYTES)
   ) u_resultStage (
      .clk    (clk),
      .arstN  (arstN),
      .exOut  (exOut),
      .fwd    (fwd),
      .regWr  (regWr),
      .retire (retire)
   );

endmodule

`default_nettype wire

// File: tests/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen (
   output logic clk,
   output logic arstN
   );

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset held for 5 cycles, released on a rising edge
   initial begin
      arstN = 1'b0;
      repeat (5) @(posedge clk);
      arstN <= 1'b1;
   end

endmodule

`default_nettype wire

// File: tests/datapath_props.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_props (
   input logic           clk,
   input logic           arstN,
   input logic           instValid,
   input cpuPkg::retireT retire
   );

   // Nothing retires while reset is held
   assert property (@(posedge clk) !arstN |-> !retire.valid)
      else $error("retire.valid high during reset");

   // X31 is never reported as a written register
   assert property (@(posedge clk) disable iff (!arstN)
      (retire.valid && retire.writes) |-> (retire.rd != 5'd31))
      else $error("retire record writes X31");

   // Fixed two cycle latency, bubbles included
   assert property (@(posedge clk) disable iff (!arstN)
      retire.valid == $past(instValid, 2))
      else $error("retire.valid does not follow instValid by two cycles");

endmodule

bind cpuDatapath datapath_props u_props (
   .clk       (clk),
   .arstN     (arstN),
   .instValid (instValid),
   .retire    (retire)
);

`default_nettype wire

// File: tests/tbCpu.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpu;

   localparam int    MAX_RECS  = 64;
   localparam int    REC_WORDS = 5;
   localparam string STIM_FILE = "tests/cpuStimulus.mem";

   logic             clk;
   logic             arstN;
   logic             instValid;
   cpuPkg::instWordT instWord;
   cpuPkg::retireT   retire;

   // Word 0 is the record count, then five words per record
   logic [63:0]      stimWords [0:MAX_RECS*REC_WORDS];
   // Expected retire records, oldest first
   cpuPkg::retireT   expQ [$];
   int               recCount;
   int               seed;
   bit               driveDone;
   int               retired;
   int               writeErrors;
   int               flagErrors;
   int               otherErrors;

   clkGen u_clkGen (
      .clk   (clk),
      .arstN (arstN)
   );

   cpuDatapath #(
      .MEM_BYTES (256)
   ) u_dut (
      .clk       (clk),
      .arstN     (arstN),
      .instValid (instValid),
      .instWord  (instWord),
      .retire    (retire)
   );

   // Unpack record idx into the retire record it should produce
   function automatic cpuPkg::retireT expectedAt(input int idx);
      cpuPkg::retireT rec;
      int base;
      base = 1 + idx * REC_WORDS;
      rec.valid = 1'b1;
      rec.writes = stimWords[base+1][0];
      rec.rd = stimWords[base+2][4:0];
      rec.data = stimWords[base+3];
      rec.flags = stimWords[base+4][3:0];
      return rec;
   endfunction

   // Data only matters when the record writes a register
   task automatic checkWrite(input string name, input cpuPkg::retireT exp,
                             input cpuPkg::retireT act);
      if (act.writes !== exp.writes || act.rd !== exp.rd) begin
         writeErrors++;
         $display("ERROR %s: expected writes=%0b rd=%0d, actual writes=%0b rd=%0d",
                  name, exp.writes, exp.rd, act.writes, act.rd);
      end else if (exp.writes && act.data !== exp.data) begin
         writeErrors++;
         $display("ERROR %s: expected data=%h, actual data=%h", name, exp.data, act.data);
      end
   endtask

   task automatic checkFlags(input string name, input cpuPkg::flagsT exp,
                             input cpuPkg::flagsT act);
      if (act !== exp) begin
         flagErrors++;
         $display("ERROR %s: expected NZVC=%b, actual NZVC=%b", name, exp, act);
      end
   endtask

   // Instruction driver
   initial begin
      int bubbleDraw;
      instValid = 1'b0;
      instWord = '0;
      seed = 12004;
      driveDone = 1'b0;
      retired = 0;
      writeErrors = 0;
      flagErrors = 0;
      otherErrors = 0;
      $readmemh(STIM_FILE, stimWords);
      recCount = int'(stimWords[0]);
      if (recCount < 1 || recCount > MAX_RECS) begin
         otherErrors++;
         $display("Stimulus file gives no usable record count (%0d)", recCount);
         recCount = 0;
      end
      @(posedge arstN);
      @(posedge clk);
      for (int i = 0; i < recCount; i++) begin
         bubbleDraw = $random(seed);
         // Roughly one bubble in four
         if (bubbleDraw[1:0] == 2'b00) begin
            instValid <= 1'b0;
            @(posedge clk);
         end
         instValid <= 1'b1;
         instWord <= stimWords[1 + i*REC_WORDS][31:0];
         expQ.push_back(expectedAt(i));
         @(posedge clk);
      end
      instValid <= 1'b0;
      driveDone = 1'b1;
   end

   // Retire monitor, sampled mid-cycle where retire is settled
   always @(negedge clk) begin
      cpuPkg::retireT expRec;
      string name;
      if (arstN && retire.valid) begin
         if (expQ.size() == 0) begin
            otherErrors++;
            $display("Extra retire record seen with nothing left to retire, rd=%0d",
                     retire.rd);
         end else begin
            expRec = expQ.pop_front();
            name = $sformatf("record %0d", retired);
            checkWrite(name, expRec, retire);
            checkFlags(name, expRec.flags, retire.flags);
         end
         retired++;
      end
   end

   // End of run once every expected record has retired
   initial begin
      @(posedge clk);
      while (!driveDone) @(posedge clk);
      while (expQ.size() != 0) @(posedge clk);
      // A few idle cycles to catch stray retires
      repeat (4) @(posedge clk);
      if (retired != recCount) begin
         otherErrors++;
         $display("Retired %0d records but %0d instructions were sent", retired, recCount);
      end
      $display("Retired %0d of %0d: %0d write errors, %0d flag errors, %0d other errors",
               retired, recCount, writeErrors, flagErrors, otherErrors);
      if (writeErrors + flagErrors + otherErrors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      int limit;
      @(posedge clk);
      // Reset, worst case one bubble per record, and the drain all fit
      limit = recCount * 4 + 50;
      repeat (limit) @(posedge clk);
      $display("Watchdog expired after %0d cycles with %0d records not retired",
               limit, expQ.size());
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/cpuStimulus.mem
// First word: record count. Then per line: instruction, writes, rd, write data, flags NZVC
// All hex; the data column of a record with writes 0 is not compared
1E
D2824681 1 01 0000000000001234 0 // MOVZ X1, #0x1234
F2B579A1 1 01 00000000ABCD1234 0 // MOVK X1, #0xABCD, LSL 16
F2FFFFE1 1 01 FFFF0000ABCD1234 0 // MOVK X1, #0xFFFF, LSL 48
F28AAAA1 1 01 FFFF0000ABCD5555 0 // MOVK X1, #0x5555
D2C1E1E2 1 02 00000F0F00000000 0 // MOVZ X2, #0x0F0F, LSL 32
8B020023 1 03 FFFF0F0FABCD5555 0 // ADD X3, X1, X2
CB010064 1 04 00000F0F00000000 0 // SUB X4, X3, X1
8A030025 1 05 FFFF0000ABCD5555 0 // AND X5, X1, X3
AA020026 1 06 FFFF0F0FABCD5555 0 // ORR X6, X1, X2
CA010067 1 07 00000F0F00000000 0 // EOR X7, X3, X1
911FFFE8 1 08 00000000000007FF 0 // ADDI X8, X31, #0x7FF
D1200109 1 09 FFFFFFFFFFFFFFFF 0 // SUBI X9, X8, #0x800
AB08012A 1 0A 00000000000007FE 1 // ADDS X10, X9, X8
EB08010B 1 0B 0000000000000000 5 // SUBS X11, X8, X8
D2EFFFEC 1 0C 7FFF000000000000 5 // MOVZ X12, #0x7FFF, LSL 48
AB0C018D 1 0D FFFE000000000000 A // ADDS X13, X12, X12
EB0C03EE 1 0E 8001000000000000 8 // SUBS X14, X31, X12
EB0C01AF 1 0F 7FFF000000000000 3 // SUBS X15, X13, X12
F80103E1 0 01 0000000000000000 3 // STUR X1, [X31, #16]
F84103F0 1 10 FFFF0000ABCD5555 3 // LDUR X16, [X31, #16]
8B100211 1 11 FFFE0001579AAAAA 3 // ADD X17, X16, X16
F81F83E9 0 09 0000000000000000 3 // STUR X9, [X31, #-8]
381F83E1 0 01 0000000000000000 3 // STURB X1, [X31, #-8]
385F83F2 1 12 0000000000000055 3 // LDURB X18, [X31, #-8]
F85F83F3 1 13 FFFFFFFFFFFFFF55 3 // LDUR X19, [X31, #-8]
8B02003F 0 1F 0000000000000000 3 // ADD X31, X1, X2
12345678 0 18 0000000000000000 3 // Unknown opcode
AA0E03F4 1 14 8001000000000000 3 // ORR X20, X31, X14
8B1F03F5 1 15 0000000000000000 3 // ADD X21, X31, X31
8B1F0316 1 16 0000000000000000 3 // ADD X22, X24, X31

// File: tb.f
design/cpuPkg.sv
design/regFile.sv
design/instDecoder.sv
design/execStage.sv
design/resultStage.sv
design/cpuDatapath.sv
tests/clkGen.sv
tests/datapath_props.sv
tests/tbCpu.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tbCpu
FILELIST := tb.f
OBJDIR   := obj_dir
LOG      := sim.log
FAIL_MSG := Simulation FAILED
PASS_MSG := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
